// ==== verilog.f ====
+incdir+hw
hw/cl_capture_pkg.sv
hw/cl_cmd_decode.sv
hw/cl_line_capture.sv
hw/cl_result_queue.sv
hw/cl_capture_top.sv
tests/tb_clock_gen.sv
tests/tb_cl_capture.sv

// ==== tests/tb_cl_capture.sv ====
`timescale 1ns/1ns
`include "cl_capture_cfg.svh"

module tb_cl_capture import cl_capture_pkg::*; ();

  localparam int DEPTH        = `CFG_QUEUE_DEPTH;
  localparam int HS_LIMIT     = 50;                   // cycles per handshake phase
  localparam int N_FRAMES     = 8;
  localparam int FRAME_CYCLES = 2 + 3 * (4 + 3) + 4;  // three lines of four pixels
  localparam int READ_CYCLES  = 60 * 4 * 8;           // entries, words, cycles per word
  localparam int WATCHDOG_NS  = (N_FRAMES * FRAME_CYCLES + READ_CYCLES + 500) * 10;

  logic       reset;          // clock
  logic       bus_clk;        // reset, active high
  logic       cmd_req;
  word_t      cmd_data;
  logic       rd_req;
  logic       cl_fval;
  logic       cl_lval;
  logic       cl_pix_valid;
  pix_t       cam_port [10];  // ports a .. j
  logic       cmd_ack;
  logic       cmd_error;
  logic       rd_ack;
  word_t      rd_data;
  logic       overflow;
  logic       capturing;

  // reference model
  cap_state_t m_state;
  logic       m_fval_d;
  logic       m_lval_d;
  frame_num_t m_frame;
  line_num_t  m_line;
  logic       m_cmd_ack;
  logic       m_arm_p;
  logic       m_stop_p;
  logic       m_cmd_error;
  int         m_count;        // entries the queue should hold
  logic       take;           // request seen, ack not yet given
  word_t      exp_q [$];      // expected read words, oldest first
  word_t      exp_head;
  logic       exp_have;
  int         words_read;
  string      test_name;

  tb_clock_gen i_tb_clock_gen (.reset(reset), .bus_clk(bus_clk));

  cl_capture_top i_cl_capture_top (
    .*,
    .cl_port_a (cam_port[0]),
    .cl_port_b (cam_port[1]),
    .cl_port_c (cam_port[2]),
    .cl_port_d (cam_port[3]),
    .cl_port_e (cam_port[4]),
    .cl_port_f (cam_port[5]),
    .cl_port_g (cam_port[6]),
    .cl_port_h (cam_port[7]),
    .cl_port_i (cam_port[8]),
    .cl_port_j (cam_port[9])
  );

  task automatic report_error(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_error(input string what, input word_t expected, input word_t actual);
    report_error($sformatf("ERROR %s %s: expected %h actual %h",
                           test_name, what, expected, actual));
  endtask

  task automatic update_head();
    exp_have = (exp_q.size() != 0);
    exp_head = exp_have ? exp_q[0] : '0;  // what the next acked word must be
  endtask

  // polls on falling edges, rd_side picks the read channel
  task automatic wait_ack(input bit rd_side, input logic level);
    int waited;
    waited = 0;
    while ((rd_side ? rd_ack : cmd_ack) !== level) begin
      @(negedge reset);
      waited++;
      if (waited > HS_LIMIT)
        report_error($sformatf("%s: %s acknowledge stuck for %0d cycles",
                               test_name, rd_side ? "read" : "command", waited));
    end
  endtask

  task automatic send_command(input word_t word);
    @(negedge reset);
    cmd_data = word;
    cmd_req  = 1'b1;
    wait_ack(1'b0, 1'b1);
    cmd_req = 1'b0;
    wait_ack(1'b0, 1'b0);
  endtask

  task automatic read_word();
    @(negedge reset);
    rd_req = 1'b1;
    wait_ack(1'b1, 1'b1);
    rd_req = 1'b0;
    wait_ack(1'b1, 1'b0);
    void'(exp_q.pop_front());
    words_read++;
    if (words_read % 4 == 0) m_count--;  // entry popped after word 3
    update_head();
  endtask

  task automatic drain_queue();
    while (exp_q.size() != 0)
      read_word();
  endtask

  // camera model, fval leads lval by two cycles
  task automatic send_frame(input bit gaps);
    @(negedge reset);
    cl_fval = 1'b1;
    repeat (2) @(negedge reset);
    for (int ln = 0; ln < 3; ln++) begin
      for (int px = 0; px < 4; px++) begin
        cl_lval      = 1'b1;
        cl_pix_valid = gaps ? ($urandom % 4 != 0) : 1'b1;
        foreach (cam_port[i])
          cam_port[i] = 8'($urandom);
        @(negedge reset);
      end
      cl_lval      = 1'b0;
      cl_pix_valid = 1'b0;
      repeat (3) @(negedge reset);  // line blanking
    end
    cl_fval = 1'b0;
    repeat (4) @(negedge reset);
  endtask

  // no word is waiting, so a request must stay unanswered
  task automatic expect_no_ack();
    @(negedge reset);
    rd_req = 1'b1;
    repeat (20) @(negedge reset);
    rd_req = 1'b0;
    repeat (2) @(negedge reset);
  endtask

  task automatic check_overflow(input logic expected);
    @(negedge reset);
    assert (overflow == expected) else value_error("overflow", expected, overflow);
  endtask

  always @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      m_state     = STANDBY;
      m_fval_d    = 1'b0;
      m_lval_d    = 1'b0;
      m_frame     = '0;
      m_line      = '0;
      m_cmd_ack   = 1'b0;
      m_arm_p     = 1'b0;
      m_stop_p    = 1'b0;
      m_cmd_error = 1'b0;
      m_count     = 0;
    end else begin
      // stamps count every frame, captured or not
      if (cl_fval && !m_fval_d) begin
        m_frame = m_frame + 1'b1;
        m_line  = '0;
      end else if (!cl_lval && m_lval_d) begin
        m_line = m_line + 1'b1;
      end
      if (m_state == CAPTURING && cl_fval && cl_lval && cl_pix_valid && m_count < DEPTH) begin
        exp_q.push_back(word_t'(m_frame));
        exp_q.push_back({cam_port[1], cam_port[0], 16'(m_line)});
        exp_q.push_back({cam_port[5], cam_port[4], cam_port[3], cam_port[2]});
        exp_q.push_back({cam_port[9], cam_port[8], cam_port[7], cam_port[6]});
        m_count++;  // a beat on a full queue is simply lost
        update_head();
      end
      if (m_stop_p) m_state = STANDBY;  // pulses act one cycle after ack
      else if (m_arm_p) m_state = ARMED;
      else if (m_state == ARMED && cl_fval && !m_fval_d) m_state = CAPTURING;
      take     = cmd_req && !m_cmd_ack;
      m_arm_p  = take && cmd_data == `CFG_CMD_ARM;
      m_stop_p = take && cmd_data == `CFG_CMD_STOP;
      if (m_arm_p) m_cmd_error = 1'b0;
      else if (take && !m_stop_p) m_cmd_error = 1'b1;
      if (take) m_cmd_ack = 1'b1;
      else if (!cmd_req) m_cmd_ack = 1'b0;
      m_fval_d = cl_fval;
      m_lval_d = cl_lval;
    end
  end

  a_reset_values: assert property (@(posedge reset)
    $fell(bus_clk) |-> !(cmd_ack || cmd_error || rd_ack || overflow || capturing))
    else report_error("outputs not all low right after reset");

  a_cmd_ack: assert property (@(posedge reset) disable iff (bus_clk) cmd_ack == m_cmd_ack)
    else value_error("cmd_ack", $sampled(m_cmd_ack), $sampled(cmd_ack));

  a_cmd_error: assert property (@(posedge reset) disable iff (bus_clk)
    cmd_error == m_cmd_error)
    else value_error("cmd_error", $sampled(m_cmd_error), $sampled(cmd_error));

  a_capturing: assert property (@(posedge reset) disable iff (bus_clk)
    capturing == (m_state == CAPTURING))
    else value_error("capturing", $sampled(m_state == CAPTURING), $sampled(capturing));

  a_ack_needs_data: assert property (@(posedge reset) disable iff (bus_clk)
    rd_ack |-> exp_have)
    else report_error($sformatf("%s: rd_ack raised with no captured word waiting",
                                test_name));

  a_read_word: assert property (@(posedge reset) disable iff (bus_clk)
    (rd_ack && exp_have) |-> rd_data == exp_head)
    else value_error("read word", $sampled(exp_head), $sampled(rd_data));

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(32'h580));
    cmd_req      = 1'b0;
    cmd_data     = '0;
    rd_req       = 1'b0;
    cl_fval      = 1'b0;
    cl_lval      = 1'b0;
    cl_pix_valid = 1'b0;
    foreach (cam_port[i])
      cam_port[i] = '0;
    exp_head   = '0;
    exp_have   = 1'b0;
    words_read = 0;
    test_name  = "reset";
    @(negedge bus_clk);
    expect_no_ack();

    test_name = "arm";
    send_frame(1'b1);  // frame 1, standby
    fork
      send_frame(1'b1);  // frame 2, armed partway
      begin
        repeat (4) @(negedge reset);
        send_command(`CFG_CMD_ARM);
      end
    join
    send_frame(1'b1);  // frame 3, first captured
    drain_queue();
    send_frame(1'b1);  // frame 4, lines restart at 0
    drain_queue();
    expect_no_ack();

    test_name = "stop";
    fork
      send_frame(1'b1);
      begin
        repeat (10) @(negedge reset);  // lands inside line 2
        send_command(`CFG_CMD_STOP);
      end
    join
    send_frame(1'b1);
    drain_queue();
    expect_no_ack();

    test_name = "unknown";
    send_command(32'hdeadbeef);
    assert (cmd_error) else value_error("cmd_error", 1, cmd_error);
    send_command(`CFG_CMD_ARM);
    assert (!cmd_error) else value_error("cmd_error", 0, cmd_error);
    send_command(`CFG_CMD_STOP);

    test_name = "backpressure";
    send_command(`CFG_CMD_ARM);
    send_frame(1'b0);  // 24 beats, no host reads
    send_frame(1'b0);
    check_overflow(1'b1);
    drain_queue();
    check_overflow(1'b1);  // sticky until re-armed
    send_command(`CFG_CMD_ARM);
    check_overflow(1'b0);
    send_command(`CFG_CMD_STOP);
    expect_no_ack();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic reset,    // clock
  output logic bus_clk   // reset, active high
);

  initial begin
    reset = 1'b0;
    forever #(PERIOD_NS / 2) reset = ~reset;
  end

  // release on a falling edge so the first rising edge sees a clean reset
  initial begin
    bus_clk = 1'b1;
    repeat (RESET_CYCLES) @(posedge reset);
    @(negedge reset);
    bus_clk = 1'b0;
  end

endmodule

// ==== hw/cl_capture_top.sv ====
`timescale 1ns/1ns

module cl_capture_top import cl_capture_pkg::*; (
  input  logic  reset,         // clock
  input  logic  bus_clk,       // async reset, active high
  input  logic  cmd_req,
  input  word_t cmd_data,
  input  logic  rd_req,
  input  logic  cl_fval,
  input  logic  cl_lval,
  input  logic  cl_pix_valid,
  input  pix_t  cl_port_a,
  input  pix_t  cl_port_b,
  input  pix_t  cl_port_c,
  input  pix_t  cl_port_d,
  input  pix_t  cl_port_e,
  input  pix_t  cl_port_f,
  input  pix_t  cl_port_g,
  input  pix_t  cl_port_h,
  input  pix_t  cl_port_i,
  input  pix_t  cl_port_j,
  output logic  cmd_ack,
  output logic  cmd_error,
  output logic  rd_ack,
  output word_t rd_data,
  output logic  overflow,
  output logic  capturing
);

  logic  arm_pulse;
  logic  stop_pulse;
  logic  beat_valid;
  beat_t beat_data;
  logic  clear_overflow;

  // command decode
  cl_cmd_decode i_cl_cmd_decode (
    .reset      (reset),
    .bus_clk    (bus_clk),
    .cmd_req    (cmd_req),
    .cmd_data   (cmd_data),
    .cmd_ack    (cmd_ack),
    .arm_pulse  (arm_pulse),
    .stop_pulse (stop_pulse),
    .cmd_error  (cmd_error)
  );

  // stamping and beat generation
  cl_line_capture i_cl_line_capture (
    .reset          (reset),
    .bus_clk        (bus_clk),
    .arm_pulse      (arm_pulse),
    .stop_pulse     (stop_pulse),
    .cl_fval        (cl_fval),
    .cl_lval        (cl_lval),
    .cl_pix_valid   (cl_pix_valid),
    .cl_port_a      (cl_port_a),
    .cl_port_b      (cl_port_b),
    .cl_port_c      (cl_port_c),
    .cl_port_d      (cl_port_d),
    .cl_port_e      (cl_port_e),
    .cl_port_f      (cl_port_f),
    .cl_port_g      (cl_port_g),
    .cl_port_h      (cl_port_h),
    .cl_port_i      (cl_port_i),
    .cl_port_j      (cl_port_j),
    .beat_valid     (beat_valid),
    .beat_data      (beat_data),
    .clear_overflow (clear_overflow),
    .capturing      (capturing)
  );

  // result queue and host readout
  cl_result_queue i_cl_result_queue (
    .reset          (reset),
    .bus_clk        (bus_clk),
    .beat_valid     (beat_valid),
    .beat_data      (beat_data),
    .clear_overflow (clear_overflow),
    .rd_req         (rd_req),
    .rd_ack         (rd_ack),
    .rd_data        (rd_data),
    .overflow       (overflow)
  );

endmodule

// ==== hw/cl_result_queue.sv ====
`timescale 1ns/1ns
`include "cl_capture_cfg.svh"

module cl_result_queue import cl_capture_pkg::*; (
  input  logic  reset,           // clock
  input  logic  bus_clk,         // async reset, active high
  input  logic  beat_valid,
  input  beat_t beat_data,
  input  logic  clear_overflow,  // from arm
  input  logic  rd_req,          // four-phase read request
  output logic  rd_ack,
  output word_t rd_data,         // steady while rd_ack high
  output logic  overflow         // sticky, beat dropped
);

  localparam int DEPTH = `CFG_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  beat_t            mem [DEPTH];  // entry storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;        // one extra bit for full
  logic [1:0]       word_idx;     // word of head entry on the bus
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic             rd_start;     // phase 2 of read handshake
  logic             rd_done;      // phase 4
  beat_t            head;

  assign full     = (count == (PTR_W + 1)'(DEPTH));
  assign empty    = (count == '0);
  assign push     = beat_valid && !full;  // no room, beat is lost
  assign rd_start = rd_req && !rd_ack && !empty;
  assign rd_done  = !rd_req && rd_ack;
  assign pop      = rd_done && (word_idx == 2'd3);
  assign head     = mem[rd_ptr];

  // word select, head only moves when ack is low
  always_comb begin
    case (word_idx)
      2'd0:    rd_data = head[127:96];  // pad, frame number
      2'd1:    rd_data = head[95:64];   // b, a, pad, line number
      2'd2:    rd_data = head[63:32];   // f .. c
      default: rd_data = head[31:0];    // j .. g
    endcase
  end

  always_ff @(posedge reset) begin
    if (push) mem[wr_ptr] <= beat_data;
  end

  // pointers and fill level
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2**n
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // read handshake and word index
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      rd_ack   <= 1'b0;
      word_idx <= 2'd0;
    end else if (rd_start) begin
      rd_ack <= 1'b1;
    end else if (rd_done) begin
      rd_ack   <= 1'b0;
      word_idx <= word_idx + 1'b1;  // wraps to 0 on pop
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      overflow <= 1'b0;
    end else if (clear_overflow) begin
      overflow <= 1'b0;
    end else if (beat_valid && full) begin
      overflow <= 1'b1;
    end
  end

  a_count_bound: assert property (
    @(posedge reset) disable iff (bus_clk)
    count <= (PTR_W + 1)'(DEPTH)
  ) else $error("queue count above depth");

  a_rd_data_stable: assert property (
    @(posedge reset) disable iff (bus_clk)
    (rd_ack && $past(rd_ack)) |-> $stable(rd_data)
  ) else $error("rd_data changed while rd_ack high");

endmodule

// ==== hw/cl_line_capture.sv ====
`timescale 1ns/1ns
`include "cl_capture_cfg.svh"

module cl_line_capture import cl_capture_pkg::*; (
  input  logic  reset,         // clock
  input  logic  bus_clk,       // async reset, active high
  input  logic  arm_pulse,
  input  logic  stop_pulse,
  input  logic  cl_fval,       // frame valid
  input  logic  cl_lval,       // line valid
  input  logic  cl_pix_valid,  // qualifies the port bytes
  input  pix_t  cl_port_a,
  input  pix_t  cl_port_b,
  input  pix_t  cl_port_c,
  input  pix_t  cl_port_d,
  input  pix_t  cl_port_e,
  input  pix_t  cl_port_f,
  input  pix_t  cl_port_g,
  input  pix_t  cl_port_h,
  input  pix_t  cl_port_i,
  input  pix_t  cl_port_j,
  output logic  beat_valid,    // one cycle per stamped beat
  output beat_t beat_data,
  output logic  clear_overflow,
  output logic  capturing
);

  cap_state_t state;
  logic       fval_d;     // last cycle's fval
  logic       lval_d;     // last cycle's lval
  logic       fval_rise;
  logic       lval_fall;
  logic       beat_ok;    // this sample goes to the queue
  frame_num_t frame_num;
  line_num_t  line_num;
  frame_num_t frame_cur;  // stamp values valid in this sample
  line_num_t  line_cur;

  assign fval_rise = cl_fval && !fval_d;
  assign lval_fall = !cl_lval && lval_d;
  assign beat_ok   = (state == CAPTURING) && cl_fval && cl_lval && cl_pix_valid;

  // a pixel on the fval rise cycle already belongs to the new frame
  assign frame_cur = fval_rise ? frame_num + 1'b1 : frame_num;
  assign line_cur  = fval_rise ? '0 : line_num;

  assign clear_overflow = arm_pulse;  // queue overflow is per arm
  assign capturing      = (state == CAPTURING);

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      fval_d <= 1'b0;
      lval_d <= 1'b0;
    end else begin
      fval_d <= cl_fval;
      lval_d <= cl_lval;
    end
  end

  // stamps count whether or not we capture
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      frame_num <= '0;
      line_num  <= '0;
    end else begin
      if (fval_rise) frame_num <= frame_num + 1'b1;
      if (fval_rise) begin
        line_num <= '0;
      end else if (lval_fall) begin
        line_num <= line_num + 1'b1;  // next line
      end
    end
  end

  // control FSM, stop wins, arm restarts from any state
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      state <= STANDBY;
    end else if (stop_pulse) begin
      state <= STANDBY;
    end else if (arm_pulse) begin
      state <= ARMED;
    end else if (state == ARMED && fval_rise) begin
      state <= CAPTURING;  // frame start
    end
  end

  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) beat_valid <= 1'b0;
    else         beat_valid <= beat_ok;
  end

  // payload, word 0 .. word 3 from the top down
  always_ff @(posedge reset) begin
    if (beat_ok) begin
      beat_data <= {{(`CFG_WORD_W - `CFG_FRAME_NUM_W){1'b0}}, frame_cur,
                    cl_port_b, cl_port_a,
                    {(2 * `CFG_PIX_W - `CFG_LINE_NUM_W){1'b0}}, line_cur,
                    cl_port_f, cl_port_e, cl_port_d, cl_port_c,
                    cl_port_j, cl_port_i, cl_port_h, cl_port_g};
    end
  end

  a_beat_in_capture: assert property (
    @(posedge reset) disable iff (bus_clk)
    beat_valid |-> $past(state == CAPTURING)
  ) else $error("beat emitted outside CAPTURING");

endmodule

// ==== hw/cl_cmd_decode.sv ====
`timescale 1ns/1ns
`include "cl_capture_cfg.svh"

module cl_cmd_decode import cl_capture_pkg::*; (
  input  logic  reset,       // clock
  input  logic  bus_clk,     // async active-high reset
  input  logic  cmd_req,     // four-phase request from host
  input  word_t cmd_data,    // held stable while cmd_req high
  output logic  cmd_ack,
  output logic  arm_pulse,   // one cycle wide on the ack rise
  output logic  stop_pulse,  // one cycle wide on the ack rise
  output logic  cmd_error    // sticky once an unknown word is seen
);

  logic is_arm;
  logic is_stop;
  logic take_cmd;  // new request not yet acked
  logic end_cmd;   // host let go of req so ack drops

  assign is_arm   = (cmd_data == `CFG_CMD_ARM);
  assign is_stop  = (cmd_data == `CFG_CMD_STOP);
  assign take_cmd = cmd_req && !cmd_ack;
  assign end_cmd  = !cmd_req && cmd_ack;

  // receiving side of the handshake
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      cmd_ack <= 1'b0;
    end else if (take_cmd) begin
      cmd_ack <= 1'b1;  // phase 2
    end else if (end_cmd) begin
      cmd_ack <= 1'b0;  // phase 4
    end
  end

  // command strobes, decoded on the acknowledging edge
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      arm_pulse  <= 1'b0;
      stop_pulse <= 1'b0;
    end else begin
      arm_pulse  <= take_cmd && is_arm;
      stop_pulse <= take_cmd && is_stop;
    end
  end

  // error flag survives until the host re-arms
  always_ff @(posedge reset or posedge bus_clk) begin
    if (bus_clk) begin
      cmd_error <= 1'b0;
    end else if (take_cmd) begin
      if (is_arm) begin
        cmd_error <= 1'b0;
      end else if (!is_stop) begin
        cmd_error <= 1'b1;  // neither code
      end
    end
  end

  // ack only ever answers a live request
  a_ack_needs_req: assert property (
    @(posedge reset) disable iff (bus_clk)
    $rose(cmd_ack) |-> $past(cmd_req)
  ) else $error("cmd_ack rose without cmd_req");

  // capture cannot be told to arm and stop at once
  a_one_pulse: assert property (
    @(posedge reset) disable iff (bus_clk)
    !(arm_pulse && stop_pulse)
  ) else $error("arm_pulse and stop_pulse high together");

endmodule

// ==== hw/cl_capture_pkg.sv ====
`include "cl_capture_cfg.svh"

package cl_capture_pkg;

  // one host word, commands in and read data out
  typedef logic [`CFG_WORD_W-1:0] word_t;

  // one camera link port (a .. j)
  typedef logic [`CFG_PIX_W-1:0] pix_t;

  // stamps
  typedef logic [`CFG_FRAME_NUM_W-1:0] frame_num_t;
  typedef logic [`CFG_LINE_NUM_W-1:0]  line_num_t;

  // packed queue entry, word 0 sits in the top 32 bits
  typedef logic [`CFG_BEAT_W-1:0] beat_t;

  // capture control
  typedef enum logic [1:0] {
    STANDBY,    // idle, nothing written
    ARMED,      // waiting for fval rise
    CAPTURING   // beats go to the queue
  } cap_state_t;

endpackage

// ==== hw/cl_capture_cfg.svh ====
`ifndef CL_CAPTURE_CFG_SVH
`define CL_CAPTURE_CFG_SVH

// host command words
`define CFG_CMD_ARM  32'h01020304  // arm, capture starts at next frame start
`define CFG_CMD_STOP 32'h05060708  // back to standby

// host word and camera port widths
`define CFG_WORD_W 32
`define CFG_PIX_W  8

// stamp counter widths
`define CFG_FRAME_NUM_W 20  // frame number, wraps silently
`define CFG_LINE_NUM_W  12  // enough for 1080 lines and then some

// one queue entry is four host words
`define CFG_BEAT_W (4 * `CFG_WORD_W)

// result queue depth in beats, power of two
`define CFG_QUEUE_DEPTH 16

`endif
